// File: logic/gfx_checker.sv
module gfx_checker
  import gfx_pkg::*;
#(
  parameter int h_width     = default_h_width,
  parameter int v_width     = default_v_width,
  parameter int pixel_width = default_pixel_width,
  parameter int cell_shift  = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   start,
  output logic                   done,

  output logic                   gfx_valid,
  output logic [h_width-1:0]     gfx_x,
  output logic [v_width-1:0]     gfx_y,
  output logic [pixel_width-1:0] gfx_pixel,
  input  logic                   gfx_ready,

  input  logic [h_width-1:0]     h_visible,
  input  logic [v_width-1:0]     v_visible
);

  logic               running;
  logic               running_next;
  logic               done_next;
  logic               valid_next;

  logic [h_width-1:0] x;
  logic [h_width-1:0] x_next;
  logic [v_width-1:0] y;
  logic [v_width-1:0] y_next;

  // cells flip every 2^cell_shift pixels in each direction
  logic               cell_odd;

  always_comb begin
    valid_next   = gfx_valid && !gfx_ready;
    x_next       = x;
    y_next       = y;
    running_next = running;
    done_next    = done;

    if (start) begin
      running_next = 1'b1;
      done_next    = 1'b0;
      x_next       = '0;
      y_next       = '0;
    end else if (running && gfx_valid && gfx_ready) begin
      if (x < h_visible - 1'b1) begin
        x_next = x + 1'b1;
      end else begin
        x_next = '0;
        if (y < v_visible - 1'b1) begin
          y_next = y + 1'b1;
        end else begin
          y_next       = '0;
          running_next = 1'b0;
          done_next    = 1'b1;
        end
      end
    end

    if (!gfx_valid || gfx_ready) begin
      valid_next = running_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gfx_valid <= 1'b0;
      running   <= 1'b0;
      done      <= 1'b0;
      x         <= '0;
      y         <= '0;
    end else begin
      gfx_valid <= valid_next;
      running   <= running_next;
      done      <= done_next;
      x         <= x_next;
      y         <= y_next;
    end
  end

  assign cell_odd  = x[cell_shift] ^ y[cell_shift];

  assign gfx_x     = x;
  assign gfx_y     = y;
  assign gfx_pixel = cell_odd ? pixel_width'(white) : pixel_width'(black);

  // position and pixel hold until the sink takes the beat
  data_stable_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    gfx_valid && !gfx_ready |=> $stable({gfx_x, gfx_y, gfx_pixel})
  );

endmodule

// File: logic/gfx_fb_writer.sv
module gfx_fb_writer
  import gfx_pkg::*;
#(
  parameter int h_width     = default_h_width,
  parameter int v_width     = default_v_width,
  parameter int pixel_width = default_pixel_width,
  parameter int fb_h_log2   = 5,
  parameter int fb_v_log2   = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   gfx_valid,
  input  logic [h_width-1:0]     gfx_x,
  input  logic [v_width-1:0]     gfx_y,
  input  logic [pixel_width-1:0] gfx_pixel,
  output logic                   gfx_ready,

  input  logic                   rd_en,
  input  logic [h_width-1:0]     rd_x,
  input  logic [v_width-1:0]     rd_y,
  output logic                   rd_valid,
  output logic [pixel_width-1:0] rd_pixel
);

  localparam int addr_width = fb_h_log2 + fb_v_log2;
  localparam int depth      = 2 ** addr_width;

  logic [pixel_width-1:0] mem [depth];

  logic [addr_width-1:0]  wr_addr;
  logic [addr_width-1:0]  rd_addr;
  logic                   wr_en;

  // row major, y in the upper address bits
  assign wr_addr   = {gfx_y[fb_v_log2-1:0], gfx_x[fb_h_log2-1:0]};
  assign rd_addr   = {rd_y[fb_v_log2-1:0], rd_x[fb_h_log2-1:0]};

  // host read owns the port for its cycle
  assign gfx_ready = !rd_en;
  assign wr_en     = gfx_valid && gfx_ready;

  // single port, read or write but never both
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pixel <= mem[rd_addr];
    end else if (wr_en) begin
      mem[wr_addr] <= gfx_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // the stream must never collide with a host read
  no_collision_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_en |-> !wr_en
  );

endmodule

// File: logic/gfx_pattern.sv
module gfx_pattern
  import gfx_pkg::*;
#(
  parameter int h_width     = default_h_width,
  parameter int v_width     = default_v_width,
  parameter int pixel_width = default_pixel_width
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   start,
  output logic                   done,

  output logic                   gfx_valid,
  output logic [h_width-1:0]     gfx_x,
  output logic [v_width-1:0]     gfx_y,
  output logic [pixel_width-1:0] gfx_pixel,
  input  logic                   gfx_ready,

  input  logic [h_width-1:0]     h_visible,
  input  logic [v_width-1:0]     v_visible
);

  logic                        running;
  logic                        running_next;
  logic                        done_next;
  logic                        valid_next;

  logic [h_width-1:0]          x;
  logic [h_width-1:0]          x_next;
  logic [v_width-1:0]          y;
  logic [v_width-1:0]          y_next;

  // eight equal columns across the visible width
  logic [h_width-1:0]          col_width;
  logic [2:0]                  col;
  logic [2:0]                  col_next;
  logic [h_width-1:0]          col_edge;
  logic [h_width-1:0]          col_edge_next;

  logic [7:0][pixel_width-1:0] col_colors;

  // index 0 is the leftmost bar
  assign col_colors = {
    pixel_width'(black), pixel_width'(blue), pixel_width'(red), pixel_width'(magenta),
    pixel_width'(green), pixel_width'(cyan), pixel_width'(yellow), pixel_width'(white)
  };

  assign col_width = h_visible >> 3;

  // running and done together give idle, running and done
  always_comb begin
    valid_next    = gfx_valid && !gfx_ready;
    x_next        = x;
    y_next        = y;
    col_next      = col;
    col_edge_next = col_edge;
    running_next  = running;
    done_next     = done;

    if (start) begin
      // the frame size may differ from the last frame
      running_next  = 1'b1;
      done_next     = 1'b0;
      x_next        = '0;
      y_next        = '0;
      col_next      = '0;
      col_edge_next = col_width;
    end else if (running && gfx_valid && gfx_ready) begin
      if (x < h_visible - 1'b1) begin
        x_next = x + 1'b1;
        // leftover pixels past the last edge stay in the last bar
        if (x == col_edge - 1'b1 && col != 3'd7) begin
          col_next      = col + 1'b1;
          col_edge_next = col_edge + col_width;
        end
      end else begin
        x_next        = '0;
        col_next      = '0;
        col_edge_next = col_width;
        if (y < v_visible - 1'b1) begin
          y_next = y + 1'b1;
        end else begin
          y_next       = '0;
          running_next = 1'b0;
          done_next    = 1'b1;
        end
      end
    end

    if (!gfx_valid || gfx_ready) begin
      valid_next = running_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gfx_valid <= 1'b0;
      running   <= 1'b0;
      done      <= 1'b0;
      x         <= '0;
      y         <= '0;
      col       <= '0;
      col_edge  <= '0;
    end else begin
      gfx_valid <= valid_next;
      running   <= running_next;
      done      <= done_next;
      x         <= x_next;
      y         <= y_next;
      col       <= col_next;
      col_edge  <= col_edge_next;
    end
  end

  assign gfx_x     = x;
  assign gfx_y     = y;
  assign gfx_pixel = col_colors[col];

  // a stalled beat is never withdrawn
  valid_held_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    gfx_valid && !gfx_ready |=> gfx_valid
  );

endmodule

// File: logic/gfx_pkg.sv
package gfx_pkg;

  // pattern mode select
  localparam logic mode_bars    = 1'b0;
  localparam logic mode_checker = 1'b1;

  // top level defaults
  localparam int default_h_width     = 12;
  localparam int default_v_width     = 12;
  localparam int default_pixel_width = 12;

  // one third of the pixel per channel
  localparam int channel_width = default_pixel_width / 3;

  // rescale a channel value from an m-bit range to an n-bit range
  function automatic int rgb_m_to_n(input int value, input int m, input int n);
    int result;
    if (n <= m) begin
      result = value >> (m - n);
    end else begin
      result = value << (n - m);
    end
    return result;
  endfunction

  // 75% levels, taken from the 10-bit SMPTE values
  localparam logic [channel_width-1:0] c_off =
    channel_width'(rgb_m_to_n(64, 10, channel_width));
  localparam logic [channel_width-1:0] c_on =
    channel_width'(rgb_m_to_n(721, 10, channel_width));

  // packed as red, green, blue from msb down
  localparam logic [default_pixel_width-1:0] white   = {c_on, c_on, c_on};
  localparam logic [default_pixel_width-1:0] yellow  = {c_on, c_on, c_off};
  localparam logic [default_pixel_width-1:0] cyan    = {c_off, c_on, c_on};
  localparam logic [default_pixel_width-1:0] green   = {c_off, c_on, c_off};
  localparam logic [default_pixel_width-1:0] magenta = {c_on, c_off, c_on};
  localparam logic [default_pixel_width-1:0] red     = {c_on, c_off, c_off};
  localparam logic [default_pixel_width-1:0] blue    = {c_off, c_off, c_on};
  localparam logic [default_pixel_width-1:0] black   = {c_off, c_off, c_off};

endpackage

// File: logic/gfx_source_select.sv
module gfx_source_select
  import gfx_pkg::*;
#(
  parameter int h_width     = default_h_width,
  parameter int v_width     = default_v_width,
  parameter int pixel_width = default_pixel_width
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   start,
  input  logic                   mode,
  output logic                   start_bars,
  output logic                   start_checker,
  input  logic                   done_bars,
  input  logic                   done_checker,
  output logic                   done,

  input  logic                   valid_bars,
  input  logic [h_width-1:0]     x_bars,
  input  logic [v_width-1:0]     y_bars,
  input  logic [pixel_width-1:0] pixel_bars,
  output logic                   ready_bars,

  input  logic                   valid_checker,
  input  logic [h_width-1:0]     x_checker,
  input  logic [v_width-1:0]     y_checker,
  input  logic [pixel_width-1:0] pixel_checker,
  output logic                   ready_checker,

  output logic                   gfx_valid,
  output logic [h_width-1:0]     gfx_x,
  output logic [v_width-1:0]     gfx_y,
  output logic [pixel_width-1:0] gfx_pixel,
  input  logic                   gfx_ready
);

  // source held for the whole frame
  logic sel_mode;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_mode <= mode_bars;
    end else if (start) begin
      sel_mode <= mode;
    end
  end

  assign start_bars    = start && (mode == mode_bars);
  assign start_checker = start && (mode == mode_checker);

  assign done          = (sel_mode == mode_checker) ? done_checker : done_bars;

  // no register on the stream path
  assign gfx_valid     = (sel_mode == mode_checker) ? valid_checker : valid_bars;
  assign gfx_x         = (sel_mode == mode_checker) ? x_checker : x_bars;
  assign gfx_y         = (sel_mode == mode_checker) ? y_checker : y_bars;
  assign gfx_pixel     = (sel_mode == mode_checker) ? pixel_checker : pixel_bars;

  assign ready_bars    = gfx_ready && (sel_mode == mode_bars);
  assign ready_checker = gfx_ready && (sel_mode == mode_checker);

  // only one generator may be streaming at a time
  one_source_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(valid_bars && valid_checker)
  );

endmodule

// File: logic/gfx_top.sv
module gfx_top
  import gfx_pkg::*;
#(
  parameter int h_width     = default_h_width,
  parameter int v_width     = default_v_width,
  parameter int pixel_width = default_pixel_width,
  parameter int fb_h_log2   = 5,
  parameter int fb_v_log2   = 4,
  parameter int cell_shift  = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   start,
  input  logic                   mode,
  input  logic [h_width-1:0]     h_visible,
  input  logic [v_width-1:0]     v_visible,
  output logic                   done,

  input  logic                   rd_en,
  input  logic [h_width-1:0]     rd_x,
  input  logic [v_width-1:0]     rd_y,
  output logic                   rd_valid,
  output logic [pixel_width-1:0] rd_pixel
);

  logic                   start_bars;
  logic                   start_checker;
  logic                   done_bars;
  logic                   done_checker;

  // bar generator stream
  logic                   valid_bars;
  logic [h_width-1:0]     x_bars;
  logic [v_width-1:0]     y_bars;
  logic [pixel_width-1:0] pixel_bars;
  logic                   ready_bars;

  // checker generator stream
  logic                   valid_checker;
  logic [h_width-1:0]     x_checker;
  logic [v_width-1:0]     y_checker;
  logic [pixel_width-1:0] pixel_checker;
  logic                   ready_checker;

  // selected stream into the framebuffer
  logic                   gfx_valid;
  logic [h_width-1:0]     gfx_x;
  logic [v_width-1:0]     gfx_y;
  logic [pixel_width-1:0] gfx_pixel;
  logic                   gfx_ready;

  gfx_source_select #(
    .h_width    (h_width),
    .v_width    (v_width),
    .pixel_width(pixel_width)
  ) select_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .mode         (mode),
    .start_bars   (start_bars),
    .start_checker(start_checker),
    .done_bars    (done_bars),
    .done_checker (done_checker),
    .done         (done),
    .valid_bars   (valid_bars),
    .x_bars       (x_bars),
    .y_bars       (y_bars),
    .pixel_bars   (pixel_bars),
    .ready_bars   (ready_bars),
    .valid_checker(valid_checker),
    .x_checker    (x_checker),
    .y_checker    (y_checker),
    .pixel_checker(pixel_checker),
    .ready_checker(ready_checker),
    .gfx_valid    (gfx_valid),
    .gfx_x        (gfx_x),
    .gfx_y        (gfx_y),
    .gfx_pixel    (gfx_pixel),
    .gfx_ready    (gfx_ready)
  );

  gfx_pattern #(
    .h_width    (h_width),
    .v_width    (v_width),
    .pixel_width(pixel_width)
  ) pattern_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start_bars),
    .done     (done_bars),
    .gfx_valid(valid_bars),
    .gfx_x    (x_bars),
    .gfx_y    (y_bars),
    .gfx_pixel(pixel_bars),
    .gfx_ready(ready_bars),
    .h_visible(h_visible),
    .v_visible(v_visible)
  );

  gfx_checker #(
    .h_width    (h_width),
    .v_width    (v_width),
    .pixel_width(pixel_width),
    .cell_shift (cell_shift)
  ) checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start_checker),
    .done     (done_checker),
    .gfx_valid(valid_checker),
    .gfx_x    (x_checker),
    .gfx_y    (y_checker),
    .gfx_pixel(pixel_checker),
    .gfx_ready(ready_checker),
    .h_visible(h_visible),
    .v_visible(v_visible)
  );

  gfx_fb_writer #(
    .h_width    (h_width),
    .v_width    (v_width),
    .pixel_width(pixel_width),
    .fb_h_log2  (fb_h_log2),
    .fb_v_log2  (fb_v_log2)
  ) writer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .gfx_valid(gfx_valid),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_pixel(gfx_pixel),
    .gfx_ready(gfx_ready),
    .rd_en    (rd_en),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_valid (rd_valid),
    .rd_pixel (rd_pixel)
  );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module gfx_tb -f verilog.f -o gfx_sim &&
./obj_dir/gfx_sim | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: test/gfx_golden.mem
// columns: test_id mode h_visible v_visible x y pixel, all hex
// pixel is 4 bits per channel, red in the high bits
1 0 20 10 0 0 bbb
1 0 20 10 5 3 bb1
1 0 20 10 a 7 1bb
1 0 20 10 d f 1b1
1 0 20 10 11 1 b1b
1 0 20 10 16 9 b11
1 0 20 10 1b c 11b
1 0 20 10 1f f 111
2 1 20 10 0 0 111
2 1 20 10 4 0 bbb
2 1 20 10 3 4 bbb
2 1 20 10 c 9 bbb
2 1 20 10 1d d 111
3 0 10 8 1 0 bbb
3 0 10 8 2 1 bb1
3 0 10 8 5 2 1bb
3 0 10 8 7 3 1b1
3 0 10 8 8 4 b1b
3 0 10 8 b 5 b11
3 0 10 8 c 6 11b
3 0 10 8 f 7 111
3 0 10 8 10 0 111
3 0 10 8 14 3 bbb
3 0 10 8 1f f 111

// File: test/gfx_tb.sv
module gfx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_records = 24;
  localparam int rec_width   = 7;
  localparam int idx_width   = $clog2(num_records * rec_width);
  // four frames of at most 512 beats, a 512 pixel read-back at two cycles
  // per read and the random host reads, with about twice that to spare
  localparam int max_cycles  = 6000;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        mode;
  logic [11:0] h_visible;
  logic [11:0] v_visible;
  logic        done;
  logic        rd_en;
  logic [11:0] rd_x;
  logic [11:0] rd_y;
  logic        rd_valid;
  logic [11:0] rd_pixel;

  // columns: test id, mode, h_visible, v_visible, x, y, pixel
  logic [15:0] golden [num_records * rec_width];
  // bar color per column, taken from the test 1 records
  logic [11:0] bar_colors [8];
  integer      seed;
  int          cycle_count = 0;

  gfx_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .mode     (mode),
    .h_visible(h_visible),
    .v_visible(v_visible),
    .done     (done),
    .rd_en    (rd_en),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_valid (rd_valid),
    .rd_pixel (rd_pixel)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  function automatic int field(input int rec, input int col);
    return int'(golden[idx_width'(rec * rec_width + col)]);
  endfunction

  function automatic int first_record(input int id);
    for (int r = 0; r < num_records; r++) begin
      if (field(r, 0) == id) begin
        return r;
      end
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs change a short time after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic run_frame(input logic m, input int h, input int v, input logic flip_mode);
    step_cycle();
    start     = 1'b1;
    mode      = m;
    h_visible = 12'(h);
    v_visible = 12'(v);
    step_cycle();
    start = 1'b0;
    check_value("done cleared after start", 0, 32'(done));
    // the selector latched the mode, so this must not reach the frame
    if (flip_mode) begin
      mode = !m;
    end
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      step_cycle();
    end
  endtask

  task automatic read_pixel(input int x, input int y, output logic [11:0] pixel);
    step_cycle();
    rd_en = 1'b1;
    rd_x  = 12'(x);
    rd_y  = 12'(y);
    check_value("rd_valid low before read", 0, 32'(rd_valid));
    step_cycle();
    check_value("rd_valid one cycle after rd_en", 1, 32'(rd_valid));
    pixel = rd_pixel;
    rd_en = 1'b0;
  endtask

  task automatic start_test(input int id, input logic flip_mode);
    int r;
    r = first_record(id);
    if (r < 0) begin
      $display("no record found in the golden file for test %0d", id);
      $display(">>> FAIL");
      $fatal(1, "missing stimulus");
    end
    run_frame(1'(field(r, 1)), field(r, 2), field(r, 3), flip_mode);
    wait_done();
  endtask

  task automatic check_test(input int id);
    logic [11:0] pixel;
    string       name;
    for (int r = 0; r < num_records; r++) begin
      if (field(r, 0) == id) begin
        read_pixel(field(r, 4), field(r, 5), pixel);
        name = $sformatf("test %0d pixel (%0d,%0d)", id, field(r, 4), field(r, 5));
        check_value(name, 32'(field(r, 6)), 32'(pixel));
      end
    end
  endtask

  task automatic load_bar_colors();
    int col_width;
    for (int r = 0; r < num_records; r++) begin
      if (field(r, 0) == 1) begin
        col_width = field(r, 2) / 8;
        bar_colors[3'(field(r, 4) / col_width)] = 12'(field(r, 6));
      end
    end
  endtask

  // bar frame with host reads at random gaps stealing the memory port
  task automatic run_with_reads(input int id);
    int          r;
    int          gap;
    logic [11:0] pixel;
    r = first_record(id);
    run_frame(1'(field(r, 1)), field(r, 2), field(r, 3), 1'b0);
    while (done !== 1'b1) begin
      gap = 1 + ($random(seed) & 7);
      repeat (gap) step_cycle();
      read_pixel($random(seed) & (field(r, 2) - 1), $random(seed) & (field(r, 3) - 1), pixel);
    end
  endtask

  task automatic check_full_bars(input int h, input int v);
    logic [11:0] pixel;
    string       name;
    int          col_width;
    col_width = h / 8;
    for (int y = 0; y < v; y++) begin
      for (int x = 0; x < h; x++) begin
        read_pixel(x, y, pixel);
        name = $sformatf("full bars pixel (%0d,%0d)", x, y);
        check_value(name, 32'(bar_colors[3'(x / col_width)]), 32'(pixel));
      end
    end
  endtask

  initial begin
    seed      = 32'h2e02;
    rst_n     = 1'b0;
    start     = 1'b0;
    mode      = 1'b0;
    h_visible = '0;
    v_visible = '0;
    rd_en     = 1'b0;
    rd_x      = '0;
    rd_y      = '0;
    $readmemh("test/gfx_golden.mem", golden);

    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_value("done after reset", 0, 32'(done));
    repeat (3) begin
      step_cycle();
      check_value("done idle before start", 0, 32'(done));
    end

    // color bars, full frame
    start_test(1, 1'b0);
    repeat (4) begin
      step_cycle();
      check_value("done held while idle", 1, 32'(done));
    end
    check_test(1);
    load_bar_colors();

    // checkerboard with the mode input flipped mid frame
    start_test(2, 1'b1);
    check_test(2);

    // smaller bar frame over the checkerboard
    start_test(3, 1'b0);
    check_test(3);

    run_with_reads(1);
    check_full_bars(field(first_record(1), 2), field(first_record(1), 3));

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verilog.f
logic/gfx_pkg.sv
logic/gfx_pattern.sv
logic/gfx_checker.sv
logic/gfx_source_select.sv
logic/gfx_fb_writer.sv
logic/gfx_top.sv
test/gfx_tb.sv
